// File: include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_XLEN         32
`define RV_NREGS        32
`define RV_RESET_PC     32'h0000_0000

`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_SYSTEM   7'b1110011

`define RV_INST_EBREAK  32'h0010_0073

`define RV_F3_ADD_SUB   3'b000
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_WORD      3'b010
`define RV_F7_ALT       7'b0100000

`endif

// File: rtl/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    // one instruction word, three ways of reading it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        OR,
        XOR
    } alu_op_e;

    typedef struct packed {
        logic                reg_wen;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic                use_imm;  // operand b from imm
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             alu_op;
        logic                mem_rd;
        logic                mem_wr;
        logic                ebreak;
        logic                illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] dat;
        logic [3:0]          sel;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_rsp_t;

endpackage

// File: rtl/inst_decode.sv
`include "rv_cfg.svh"

module inst_decode import rv_pkg::*; (
    input  inst_u     inst,
    output dec_ctrl_t ctrl
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_u;
    alu_op_e             f3_op;
    logic                f3_ok;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
    assign imm_u = {inst.i_fmt.imm, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'h000}; // upper 20

    // funct3 to alu op for OP and OP-IMM
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            `RV_F3_ADD_SUB: f3_op = ADD;
            `RV_F3_SLT:     f3_op = SLT;
            `RV_F3_SLTU:    f3_op = SLTU;
            `RV_F3_XOR:     f3_op = XOR;
            `RV_F3_OR:      f3_op = OR;
            `RV_F3_AND:     f3_op = AND;
            default: begin
                f3_op = ADD;
                f3_ok = 1'b0;  // shifts
            end
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.rd      = inst.r_fmt.rd;
        ctrl.rs1     = inst.r_fmt.rs1;
        ctrl.rs2     = inst.r_fmt.rs2;
        ctrl.alu_op  = ADD;
        ctrl.illegal = 1'b1;  // cleared by each kept encoding
        case (opcode)
            `RV_OPC_OP: begin
                if (f3_ok && funct7 == 7'b0000000) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.alu_op  = f3_op;
                    ctrl.illegal = 1'b0;
                end else if (funct3 == `RV_F3_ADD_SUB && funct7 == `RV_F7_ALT) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.alu_op  = SUB;
                    ctrl.illegal = 1'b0;
                end
            end
            `RV_OPC_OP_IMM: begin
                if (f3_ok) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.use_imm = 1'b1;
                    ctrl.imm     = imm_i;
                    ctrl.alu_op  = f3_op;
                    ctrl.illegal = 1'b0;
                end
            end
            `RV_OPC_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.rs1     = 5'd0;  // x0 + imm
                ctrl.use_imm = 1'b1;
                ctrl.imm     = imm_u;
                ctrl.illegal = 1'b0;
            end
            `RV_OPC_LOAD: begin
                if (funct3 == `RV_F3_WORD) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.use_imm = 1'b1;
                    ctrl.imm     = imm_i;
                    ctrl.mem_rd  = 1'b1;
                    ctrl.illegal = 1'b0;
                end
            end
            `RV_OPC_STORE: begin
                if (funct3 == `RV_F3_WORD) begin
                    ctrl.use_imm = 1'b1;
                    ctrl.imm     = imm_s;
                    ctrl.mem_wr  = 1'b1;
                    ctrl.illegal = 1'b0;
                end
            end
            `RV_OPC_SYSTEM: begin
                if (inst == `RV_INST_EBREAK) begin
                    ctrl.ebreak  = 1'b1;
                    ctrl.illegal = 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/exec_unit.sv
`include "rv_cfg.svh"

module exec_unit import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  dec_ctrl_t           ctrl,
    input  logic                issue,
    input  logic                load_wen,
    input  logic [4:0]          load_rd,
    input  logic [`RV_XLEN-1:0] load_data,
    output logic [`RV_XLEN-1:0] agu_addr,
    output logic [`RV_XLEN-1:0] store_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic                alu_wen;
    logic                wr_en;
    logic [4:0]          wr_addr;
    logic [`RV_XLEN-1:0] wr_data;

    // x0 is never written, force the read
    assign rs1_val = (ctrl.rs1 == 5'd0) ? '0 : regs[ctrl.rs1];
    assign rs2_val = (ctrl.rs2 == 5'd0) ? '0 : regs[ctrl.rs2];

    assign op_b = ctrl.use_imm ? ctrl.imm : rs2_val;

    always_comb begin
        alu_res = '0;
        case (ctrl.alu_op)
            ADD:     alu_res = rs1_val + op_b;
            SUB:     alu_res = rs1_val - op_b;
            SLT:     alu_res[0] = $signed(rs1_val) < $signed(op_b);
            SLTU:    alu_res[0] = rs1_val < op_b;
            AND:     alu_res = rs1_val & op_b;
            OR:      alu_res = rs1_val | op_b;
            XOR:     alu_res = rs1_val ^ op_b;
            default: alu_res = rs1_val + op_b;
        endcase
    end

    // lw and sw decode to ADD with imm, so the alu is the agu
    assign agu_addr   = alu_res;
    assign store_data = rs2_val;

    // issue and load ack never coincide, lsu busy blocks issue
    assign alu_wen = issue && ctrl.reg_wen && !ctrl.mem_rd && !ctrl.mem_wr;
    assign wr_en   = alu_wen || load_wen;
    assign wr_addr = load_wen ? load_rd : ctrl.rd;
    assign wr_data = load_wen ? load_data : alu_res;

    always_ff @(posedge clk) begin
        if (!rst && wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: rtl/fetch_seq.sv
`include "rv_cfg.svh"

module fetch_seq import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output wb_req_t   fetch_req,
    input  wb_rsp_t   fetch_rsp,
    output inst_u     inst,
    input  dec_ctrl_t ctrl,
    input  logic      lsu_busy,
    output logic      issue,
    output logic      halted,
    output logic      illegal
);

    logic [`RV_XLEN-1:0] pc;       // address of next word to fetch
    logic                buf_valid;
    logic                cyc_q;
    logic                stop;

    assign issue = buf_valid && !lsu_busy;
    assign stop  = ctrl.ebreak || ctrl.illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= `RV_RESET_PC;
            buf_valid <= 1'b0;
            cyc_q     <= 1'b0;
            halted    <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            if (cyc_q && fetch_rsp.ack) begin
                cyc_q     <= 1'b0;
                buf_valid <= 1'b1;
                pc        <= pc + `RV_XLEN'd4;
            end else if (issue) begin
                buf_valid <= 1'b0;
                cyc_q     <= !stop;  // prefetch unless halting
            end else if (!cyc_q && !buf_valid && !halted) begin
                cyc_q <= 1'b1;       // first fetch out of reset
            end
            if (issue && stop) begin
                halted <= 1'b1;
            end
            if (issue && ctrl.illegal) begin
                illegal <= 1'b1;
            end
        end
    end

    // one-entry buffer
    always_ff @(posedge clk) begin
        if (cyc_q && fetch_rsp.ack) begin
            inst <= fetch_rsp.dat;
        end
    end

    always_comb begin
        fetch_req     = '0;
        fetch_req.cyc = cyc_q;
        fetch_req.stb = cyc_q;
        fetch_req.adr = pc;
        fetch_req.sel = 4'hf;
    end

endmodule

// File: rtl/lsu.sv
`include "rv_cfg.svh"

module lsu import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  dec_ctrl_t           ctrl,
    input  logic                issue,
    input  logic [`RV_XLEN-1:0] agu_addr,
    input  logic [`RV_XLEN-1:0] store_data,
    output wb_req_t             lsu_req,
    input  wb_rsp_t             lsu_rsp,
    output logic                busy,
    output logic                load_wen,
    output logic [4:0]          load_rd,
    output logic [`RV_XLEN-1:0] load_data
);

    logic                start;
    logic                busy_q;
    logic                we_q;
    logic [`RV_XLEN-1:0] adr_q;
    logic [`RV_XLEN-1:0] dat_q;
    logic [4:0]          rd_q;

    assign start = issue && (ctrl.mem_rd || ctrl.mem_wr);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if (busy_q && lsu_rsp.ack) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q  <= ctrl.mem_wr;
            adr_q <= agu_addr;
            dat_q <= store_data;
            rd_q  <= ctrl.rd;
        end
    end

    assign busy = busy_q;  // high through the ack cycle

    assign lsu_req = '{cyc: busy_q, stb: busy_q, we: we_q, adr: adr_q, dat: dat_q, sel: 4'hf};

    assign load_wen  = busy_q && lsu_rsp.ack && !we_q;
    assign load_rd   = rd_q;
    assign load_data = lsu_rsp.dat;

endmodule

// File: rtl/wb_arbiter.sv
module wb_arbiter import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t fetch_req,
    output wb_rsp_t fetch_rsp,
    input  wb_req_t lsu_req,
    output wb_rsp_t lsu_rsp,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    logic grant_q;  // a master owns the bus
    logic owner_q;  // 1 = lsu
    logic owner;
    logic owner_cyc;

    // idle bus passes the winner through in the same cycle, lsu first
    assign owner     = grant_q ? owner_q : lsu_req.cyc;
    assign owner_cyc = owner_q ? lsu_req.cyc : fetch_req.cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= 1'b0;
            owner_q <= 1'b0;
        end else if (!grant_q) begin
            if (fetch_req.cyc || lsu_req.cyc) begin
                grant_q <= 1'b1;
                owner_q <= lsu_req.cyc;
            end
        end else if (!owner_cyc) begin
            grant_q <= 1'b0;  // owner dropped cyc
        end
    end

    assign bus_req = owner ? lsu_req : fetch_req;

    always_comb begin
        fetch_rsp = '0;
        lsu_rsp   = '0;
        if (owner) begin
            lsu_rsp = bus_rsp;
        end else begin
            fetch_rsp = bus_rsp;
        end
    end

endmodule

// File: rtl/rv_core_top.sv
`include "rv_cfg.svh"

module rv_core_top import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp,
    output logic    halted,
    output logic    illegal
);

    wb_req_t             fetch_req;
    wb_rsp_t             fetch_rsp;
    wb_req_t             lsu_req;
    wb_rsp_t             lsu_rsp;
    inst_u               inst;
    dec_ctrl_t           ctrl;
    logic                issue;
    logic                lsu_busy;
    logic                load_wen;
    logic [4:0]          load_rd;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] agu_addr;
    logic [`RV_XLEN-1:0] store_data;

    fetch_seq u_fetch_seq (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .inst      (inst),
        .ctrl      (ctrl),
        .lsu_busy  (lsu_busy),
        .issue     (issue),
        .halted    (halted),
        .illegal   (illegal)
    );

    inst_decode u_inst_decode (
        .inst (inst),
        .ctrl (ctrl)
    );

    exec_unit u_exec_unit (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .issue      (issue),
        .load_wen   (load_wen),
        .load_rd    (load_rd),
        .load_data  (load_data),
        .agu_addr   (agu_addr),
        .store_data (store_data)
    );

    lsu u_lsu (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .issue      (issue),
        .agu_addr   (agu_addr),
        .store_data (store_data),
        .lsu_req    (lsu_req),
        .lsu_rsp    (lsu_rsp),
        .busy       (lsu_busy),
        .load_wen   (load_wen),
        .load_rd    (load_rd),
        .load_data  (load_data)
    );

    wb_arbiter u_wb_arbiter (
        .clk       (clk),
        .rst       (rst),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

endmodule

// File: bench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst,
    input  logic rst_req
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // power-on reset, then again on each request
    always begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge rst_req);
    end

endmodule

// File: bench/rv_core_chk.sv
module rv_core_chk import rv_pkg::*; (
    input logic    clk,
    input logic    rst,
    input wb_req_t bus_req,
    input wb_rsp_t bus_rsp,
    input logic    halted
);

    timeunit 1ns;
    timeprecision 1ps;

    a_stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        bus_req.stb |-> bus_req.cyc)
        else $error("wishbone stb high without cyc");

    // classic cycle holds everything until ack
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (bus_req.stb && !bus_rsp.ack) |=> (bus_req.stb && $stable(bus_req)))
        else $error("wishbone request changed before ack");

    a_no_cyc_after_halt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !$rose(bus_req.cyc))
        else $error("new bus cycle started while halted");

endmodule

bind rv_core_top rv_core_chk u_rv_core_chk (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .halted  (halted)
);

// File: bench/rv_core_tb.sv
`include "rv_cfg.svh"

module rv_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        rst_req = 1'b0;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp = '0;
    logic        halted;
    logic        illegal;

    logic [31:0] mem [1024];
    logic [31:0] ref_mem [1024];
    logic        ref_illegal;
    logic [31:0] lcg_state = 32'hff55;
    int          prog_idx;
    int          errors = 0;
    int          checks = 0;
    bit          timed_out = 1'b0;
    string       cur_name;
    event        compare_req;
    bit          cmp_done;
    bit          pending = 1'b0;
    logic [31:0] delay;

    tb_clk_gen u_tb_clk_gen (
        .clk     (clk),
        .rst     (rst),
        .rst_req (rst_req)
    );

    rv_core_top u_rv_core_top (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .halted  (halted),
        .illegal (illegal)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return 32'h9e37_79b9 * ({22'h0, idx} + 32'd1);
    endfunction

    function automatic logic [31:0] op_r(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        inst_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = `RV_OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] op_i(input logic [6:0] opc, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        inst_u w;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] op_sw(input logic [4:0] rs2, input logic [11:0] off);
        inst_u w;
        w.s_fmt.imm_hi = off[11:5];
        w.s_fmt.rs2    = rs2;
        w.s_fmt.rs1    = 5'd0;
        w.s_fmt.funct3 = `RV_F3_WORD;
        w.s_fmt.imm_lo = off[4:0];
        w.s_fmt.opcode = `RV_OPC_STORE;
        return w;
    endfunction

    function automatic logic [31:0] op_lw(input logic [4:0] rd, input logic [11:0] off);
        return op_i(`RV_OPC_LOAD, `RV_F3_WORD, rd, 5'd0, off);
    endfunction

    function automatic logic [31:0] op_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `RV_OPC_LUI};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // runs the program on ref_mem until ebreak or an unknown word
    function automatic void run_reference();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [2:0]  f3;
        bit          f3_ok;
        bit          stop;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        pc          = `RV_RESET_PC;
        ref_illegal = 1'b0;
        stop        = 1'b0;
        steps       = 0;
        while (!stop && steps < 4096) begin
            w     = ref_mem[pc[11:2]];
            a     = r[w[19:15]];
            b     = r[w[24:20]];
            f3    = w[14:12];
            f3_ok = (f3 != 3'd1) && (f3 != 3'd5);
            imm   = {{20{w[31]}}, w[31:20]};
            pc    = pc + 32'd4;
            steps++;
            case (w[6:0])
                `RV_OPC_OP: begin
                    if (w[31:25] == 7'd0 && f3_ok) begin
                        r[w[11:7]] = alu_ref(f3, 1'b0, a, b);
                    end else if (w[31:25] == `RV_F7_ALT && f3 == 3'd0) begin
                        r[w[11:7]] = alu_ref(f3, 1'b1, a, b);
                    end else begin
                        ref_illegal = 1'b1;
                    end
                end
                `RV_OPC_OP_IMM: begin
                    if (f3_ok) begin
                        r[w[11:7]] = alu_ref(f3, 1'b0, a, imm);
                    end else begin
                        ref_illegal = 1'b1;
                    end
                end
                `RV_OPC_LUI: r[w[11:7]] = {w[31:12], 12'h000};
                `RV_OPC_LOAD: begin
                    addr = a + imm;
                    if (f3 == 3'd2) begin
                        r[w[11:7]] = ref_mem[addr[11:2]];
                    end else begin
                        ref_illegal = 1'b1;
                    end
                end
                `RV_OPC_STORE: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    if (f3 == 3'd2) begin
                        ref_mem[addr[11:2]] = b;
                    end else begin
                        ref_illegal = 1'b1;
                    end
                end
                `RV_OPC_SYSTEM: begin
                    if (w == `RV_INST_EBREAK) begin
                        stop = 1'b1;
                    end else begin
                        ref_illegal = 1'b1;
                    end
                end
                default: ref_illegal = 1'b1;
            endcase
            if (ref_illegal) begin
                stop = 1'b1;
            end
            r[0] = '0;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic emit(input logic [31:0] w);
        mem[prog_idx] = w;
        prog_idx++;
    endtask

    // wishbone slave memory with random ack delay of 0 to 3 cycles
    always @(negedge clk) begin
        if (rst) begin
            bus_rsp <= '0;
            pending = 1'b0;
        end else if (bus_rsp.ack) begin
            bus_rsp <= '0;
        end else if (bus_req.cyc && bus_req.stb) begin
            if (!pending) begin
                pending = 1'b1;
                delay   = lcg_next() % 32'd4;
            end
            if (delay == 32'd0) begin
                pending = 1'b0;
                bus_rsp.ack <= 1'b1;
                check({cur_name, " sel"}, 32'h0000_000f, {28'd0, bus_req.sel});
                if (bus_req.we) begin
                    mem[bus_req.adr[11:2]] = bus_req.dat;
                end else begin
                    bus_rsp.dat <= mem[bus_req.adr[11:2]];
                end
            end else begin
                delay = delay - 32'd1;
            end
        end
    end

    always @(compare_req) begin
        for (int i = 0; i < 1024; i++) begin
            check($sformatf("%s mem[%0d]", cur_name, i), ref_mem[i], mem[i]);
        end
        check({cur_name, " halted"}, 32'd1, {31'd0, halted});
        check({cur_name, " illegal"}, {31'd0, ref_illegal}, {31'd0, illegal});
        cmp_done = 1'b1;
    end

    function automatic string test_name(input int kind);
        case (kind)
            1:       return "alu_reg";
            2:       return "alu_imm_lui";
            3:       return "x0";
            4:       return "load_store";
            5:       return "ebreak";
            default: return "illegal";
        endcase
    endfunction

    task automatic build_program(input int kind);
        logic [2:0] f3s [7];
        f3s = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd7, 3'd6, 3'd4};
        prog_idx = 0;
        case (kind)
            1: begin
                mem[256] = lcg_next();
                mem[257] = lcg_next();
                emit(op_lw(5'd1, 12'h400));
                emit(op_lw(5'd2, 12'h404));
                for (int k = 0; k < 7; k++) begin
                    emit(op_r((k == 1) ? `RV_F7_ALT : 7'd0, f3s[k], 5'(k + 3), 5'd1, 5'd2));
                    emit(op_sw(5'(k + 3), 12'(12'h500 + 4 * k)));
                end
                emit(`RV_INST_EBREAK);
            end
            2: begin
                mem[256] = 32'hffff_ff80;
                mem[257] = 32'h0000_1234;
                emit(op_lw(5'd1, 12'h400));
                emit(op_lw(5'd2, 12'h404));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd3, 5'd1, 12'hffb));  // -5
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_SLT, 5'd4, 5'd1, 12'hfff));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_SLTU, 5'd5, 5'd2, 12'hfff));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_AND, 5'd6, 5'd2, 12'h7f0));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_OR, 5'd7, 5'd1, 12'h0ff));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_XOR, 5'd8, 5'd2, 12'hfff));
                emit(op_lui(5'd9, 20'h12345));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd9, 5'd9, 12'h678));
                emit(op_lui(5'd10, 20'hfffff));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd10, 5'd10, 12'h800));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_SLT, 5'd11, 5'd2, 12'd100));
                for (int k = 0; k < 9; k++) begin
                    emit(op_sw(5'(k + 3), 12'(12'h500 + 4 * k)));
                end
                emit(`RV_INST_EBREAK);
            end
            3: begin
                mem[256] = 32'hdead_beef;
                emit(op_lw(5'd1, 12'h400));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd0, 5'd0, 12'h123));
                emit(op_r(7'd0, `RV_F3_ADD_SUB, 5'd0, 5'd1, 5'd1));
                emit(op_lw(5'd0, 12'h400));  // load into x0 is dropped
                emit(op_sw(5'd0, 12'h500));
                emit(op_r(7'd0, `RV_F3_OR, 5'd2, 5'd0, 5'd0));
                emit(op_sw(5'd2, 12'h504));
                emit(op_r(7'd0, `RV_F3_ADD_SUB, 5'd3, 5'd0, 5'd1));
                emit(op_sw(5'd3, 12'h508));
                emit(`RV_INST_EBREAK);
            end
            4: begin
                for (int k = 0; k < 8; k++) begin
                    mem[256 + k] = lcg_next();
                    emit(op_lw(5'(k + 1), 12'(12'h400 + 4 * k)));
                    emit(op_sw(5'(k + 1), 12'(12'h600 + 4 * k)));
                end
                for (int k = 0; k < 8; k++) begin
                    emit(op_lw(5'(k + 9), 12'(12'h600 + 4 * k)));
                    emit(op_sw(5'(k + 9), 12'(12'h700 + 4 * k)));
                end
                emit(`RV_INST_EBREAK);
            end
            5: begin
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd1, 5'd0, 12'd7));
                emit(op_sw(5'd1, 12'h600));
                emit(`RV_INST_EBREAK);
                emit(op_sw(5'd1, 12'h604));
            end
            default: begin
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd1, 5'd0, 12'd5));
                emit(op_i(`RV_OPC_OP_IMM, `RV_F3_ADD_SUB, 5'd2, 5'd0, 12'd3));
                emit(op_sw(5'd1, 12'h600));
                emit(op_r(7'b0000001, 3'd0, 5'd3, 5'd1, 5'd2));  // mul
                emit(op_sw(5'd2, 12'h604));
                emit(`RV_INST_EBREAK);
            end
        endcase
    endtask

    task automatic run_test(input int kind);
        int e0;
        int c0;
        int cnt;
        cur_name = test_name(kind);
        e0       = errors;
        c0       = checks;
        cnt      = 0;
        @(negedge clk);
        if (!rst) begin
            rst_req = 1'b1;
        end
        while (!rst && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        rst_req = 1'b0;
        if (!rst) begin
            $display("timeout: reset never asserted before test %s", cur_name);
            timed_out = 1'b1;
            return;
        end
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(10'(i));
        end
        build_program(kind);
        ref_mem = mem;
        run_reference();
        cnt = 0;
        while (rst && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (rst) begin
            $display("timeout: reset never released in test %s", cur_name);
            timed_out = 1'b1;
            return;
        end
        cnt = 0;
        while (!halted && cnt < 5000) begin
            @(negedge clk);
            cnt++;
        end
        if (!halted) begin
            $display("timeout: core never halted in test %s", cur_name);
            timed_out = 1'b1;
            return;
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check({cur_name, " bus idle"}, 32'd0, {31'd0, bus_req.cyc});
        end
        cmp_done = 1'b0;
        ->compare_req;
        cnt = 0;
        while (!cmp_done && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        if (!cmp_done) begin
            $display("timeout: memory comparison did not finish in test %s", cur_name);
            timed_out = 1'b1;
            return;
        end
        $display("test %s: %0d checks, %0d errors", cur_name, checks - c0, errors - e0);
    endtask

    initial begin
        for (int k = 1; k <= 6; k++) begin
            if (!timed_out) begin
                run_test(k);
            end
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
rtl/rv_pkg.sv
rtl/inst_decode.sv
rtl/exec_unit.sv
rtl/fetch_seq.sv
rtl/lsu.sv
rtl/wb_arbiter.sv
rtl/rv_core_top.sv
bench/tb_clk_gen.sv
bench/rv_core_chk.sv
bench/rv_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
